// File: bench/meas_checker.sv
`timescale 1ns/1ps
`default_nettype none

module meas_checker (
  input  wire clk,
  input  wire reset,
  input  wire adc_start,
  input  wire adc_busy,
  input  wire adc_done
);

  // failure tallies, summed for the bench
  int start_fails = 0;
  int done_fails  = 0;
  int busy_fails  = 0;
  int fail_total;

  assign fail_total = start_fails + done_fails + busy_fails;

  // the sequencer may only trigger an idle timer
  start_idle_a: assert property (@(posedge clk) disable iff (reset)
    adc_start |-> !adc_busy)
    else
    begin
      start_fails = start_fails + 1;
      $error("adc start raised while the timer was busy");
    end

  // done is a strobe, never two cycles in a row
  done_pulse_a: assert property (@(posedge clk) disable iff (reset)
    adc_done |=> !adc_done)
    else
    begin
      done_fails = done_fails + 1;
      $error("adc done held for more than one cycle");
    end

  // busy only drops on the edge right after done
  busy_end_a: assert property (@(posedge clk) disable iff (reset)
    $fell(adc_busy) |-> $past(adc_done))
    else
    begin
      busy_fails = busy_fails + 1;
      $error("adc busy fell without a preceding done");
    end

endmodule

`default_nettype wire

// File: bench/meas_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "meas_defines.svh"

module meas_scoreboard (
  input  wire                      clk,
  input  wire                      reset,
  input  wire [7:0]                row_id,
  input  wire                      run,
  input  wire                      az_enable,
  input  wire [`MEAS_SETTLE_W-1:0] settle_duration,
  input  wire [`MEAS_DUR_W-1:0]    sample_duration,
  input  wire                      az_switch,
  input  wire                      sample_valid,
  input  wire                      sample_kind,
  input  wire [`MEAS_SEQ_W-1:0]    sample_seq,
  input  wire [`MEAS_MON_W-1:0]    monitor,
  output int                       error_count,
  output int                       strobe_count
);
  import meas_pkg::*;

  localparam logic [`MEAS_SEQ_W-1:0] SEQ_STEP = 1;

  sample_kind_t            last_kind;
  sample_kind_t            exp_kind;
  logic [`MEAS_SEQ_W-1:0]  exp_seq;
  logic                    run_d;
  logic                    valid_d;
  logic                    switch_d;
  logic                    started;
  logic                    have_prev;
  int                      cycle;
  int                      last_strobe;
  int                      gap;
  int                      low_strobes;
  int                      busy_len;
  int                      start_hits;
  int                      exp_busy;

  task automatic report_mismatch(input string name, input int exp_val, input int act_val);
    error_count = error_count + 1;
    $display("[FAIL] row %0d %s: expected %0d actual %0d", row_id, name, exp_val, act_val);
  endtask

  task automatic report_problem(input string what);
    error_count = error_count + 1;
    $display("error in row %0d: %s", row_id, what);
  endtask

  // everything is sampled on the rising edge, before the DUT updates
  always @(posedge clk)
  begin
    if (reset)
    begin
      error_count  = 0;
      strobe_count = 0;
      cycle        = 0;
      last_strobe  = 0;
      low_strobes  = 0;
      busy_len     = 0;
      start_hits   = 0;
      exp_seq      = '0;
      last_kind    = KIND_SIGNAL;
      run_d        = 1'b0;
      valid_d      = 1'b0;
      switch_d     = 1'b0;
      started      = 1'b0;
      have_prev    = 1'b0;
    end
    else
    begin
      cycle = cycle + 1;
      // one sample is S + D + 6 cycles from strobe to strobe
      gap = int'(settle_duration) + int'(sample_duration) + 6;

      // run only rises from halt, so the zero input comes first
      if (run && !run_d)
      begin
        started     = 1'b1;
        last_kind   = KIND_SIGNAL;
        have_prev   = 1'b0;
        low_strobes = 0;
      end

      // nothing moves before the first run
      if (!started)
      begin
        if (sample_valid)
          report_mismatch("idle_valid", 0, 1);
        if (az_switch)
          report_mismatch("idle_switch", 0, 1);
        if (monitor != '0)
          report_mismatch("idle_monitor", 0, int'(monitor));
      end

      // switch never leaves the signal input with auto-zero off
      if (started && !az_enable && az_switch)
        report_mismatch("az_off_switch", 0, 1);

      // monitor holds copies delayed by one register
      if (monitor[`MON_VALID] != valid_d)
        report_mismatch("monitor_valid", int'(valid_d), int'(monitor[`MON_VALID]));
      if (monitor[`MON_SWITCH] != switch_d)
        report_mismatch("monitor_switch", int'(switch_d), int'(monitor[`MON_SWITCH]));

      // length of the current busy stretch on the monitor
      // and the arm marks seen inside it
      if (monitor[`MON_BUSY])
        busy_len = busy_len + 1;
      else
      begin
        busy_len   = 0;
        start_hits = 0;
      end
      if (monitor[`MON_START])
      begin
        if (!monitor[`MON_BUSY])
          report_problem("monitor start mark appeared outside a busy period");
        start_hits = start_hits + 1;
      end

      if (sample_valid)
      begin
        strobe_count = strobe_count + 1;
        // alternate with auto-zero on, signal only otherwise
        exp_kind  = (az_enable && (last_kind == KIND_SIGNAL)) ? KIND_ZERO : KIND_SIGNAL;
        last_kind = exp_kind;
        if (sample_kind != exp_kind)
          report_mismatch("kind", int'(exp_kind), int'(sample_kind));
        // switch still shows the sampled input during the strobe
        if (az_switch != (exp_kind == KIND_ZERO))
          report_mismatch("switch", int'(exp_kind == KIND_ZERO), int'(az_switch));
        if (sample_seq != exp_seq)
          report_mismatch("seq", int'(exp_seq), int'(sample_seq));
        exp_seq = exp_seq + SEQ_STEP;
        if (have_prev && ((cycle - last_strobe) != gap))
          report_mismatch("spacing", gap, cycle - last_strobe);
        have_prev   = 1'b1;
        last_strobe = cycle;
        // timer busy from the start edge to the edge after done, D + 4 cycles
        // the monitor copy ends right as the strobe is seen
        exp_busy = int'(sample_duration) + 4;
        if (busy_len != exp_busy)
          report_mismatch("busy_span", exp_busy, busy_len);
        if (start_hits != 1)
          report_mismatch("start_marks", 1, start_hits);
        // the sample in flight when run fell may still report
        if (!run)
        begin
          low_strobes = low_strobes + 1;
          if (low_strobes > 1)
            report_problem("more than one sample strobe came after run fell");
        end
      end

      run_d    = run;
      valid_d  = sample_valid;
      switch_d = az_switch;
    end
  end

endmodule

`default_nettype wire

// File: bench/meas_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "meas_defines.svh"

module meas_tb;
  import meas_pkg::*;

  localparam int ROWS         = 6;
  localparam int RESET_CYCLES = 8;
  localparam int QUIET_CYCLES = 20;
  localparam int SEED         = 99585;

  // stimulus table, one row per test
  // columns: auto-zero enable, settle S, duration D, strobes to collect
  // last row gets random S and D at start
  logic tbl_az     [ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  int   tbl_settle [ROWS] = '{4, 3, 0, 1, 2, 0};
  int   tbl_dur    [ROWS] = '{10, 6, 0, 1, 3, 0};
  int   tbl_count  [ROWS] = '{5, 6, 4, 250, 4, 5};

  logic                    clk;
  logic                    reset;
  logic                    run;
  logic                    az_enable;
  logic [`MEAS_SETTLE_W-1:0] settle_duration;
  logic [`MEAS_DUR_W-1:0]  sample_duration;
  logic                    az_switch;
  logic                    sample_valid;
  sample_kind_t            sample_kind;
  logic [`MEAS_SEQ_W-1:0]  sample_seq;
  logic [`MEAS_MON_W-1:0]  monitor;
  logic [7:0]              row_id;
  int                      sb_errors;
  int                      sb_strobes;
  int                      cycle_count = 0;
  int                      cycle_limit = 0;

  meas_top dut_i (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .az_enable       (az_enable),
    .settle_duration (settle_duration),
    .sample_duration (sample_duration),
    .az_switch       (az_switch),
    .sample_valid    (sample_valid),
    .sample_kind     (sample_kind),
    .sample_seq      (sample_seq),
    .monitor         (monitor)
  );

  meas_scoreboard sb_i (
    .clk             (clk),
    .reset           (reset),
    .row_id          (row_id),
    .run             (run),
    .az_enable       (az_enable),
    .settle_duration (settle_duration),
    .sample_duration (sample_duration),
    .az_switch       (az_switch),
    .sample_valid    (sample_valid),
    .sample_kind     (sample_kind),
    .sample_seq      (sample_seq),
    .monitor         (monitor),
    .error_count     (sb_errors),
    .strobe_count    (sb_strobes)
  );

  // handshake assertions ride along inside the timer
  bind adc_timer meas_checker chk_i (
    .clk       (clk),
    .reset     (reset),
    .adc_start (adc_start),
    .adc_busy  (adc_busy),
    .adc_done  (adc_done)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // run limit, set once the table is known
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
    begin
      $display("timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // one table row: configure, collect strobes, stop, wait for quiet
  task automatic apply_row(input int r);
    int seen;
    int idle;
    int gap;
    seen = 0;
    idle = 0;
    gap  = tbl_settle[r] + tbl_dur[r] + 6;
    @(posedge clk);
    row_id          <= 8'(r);
    az_enable       <= tbl_az[r];
    settle_duration <= 16'(tbl_settle[r]);
    sample_duration <= 32'(tbl_dur[r]);
    run             <= 1'b1;
    while (seen < tbl_count[r])
    begin
      @(posedge clk);
      if (sample_valid)
        seen = seen + 1;
    end
    run <= 1'b0;
    // a full sample period plus slack without any strobe means halted
    while (idle < gap + QUIET_CYCLES)
    begin
      @(posedge clk);
      if (sample_valid)
        idle = 0;
      else
        idle = idle + 1;
    end
  endtask

  initial
  begin
    int r;
    int want_strobes;
    int bench_errors;
    int assert_fails;
    clk             = 1'b0;
    reset           = 1'b1;
    run             = 1'b0;
    az_enable       = 1'b0;
    settle_duration = '0;
    sample_duration = '0;
    row_id          = '0;
    bench_errors    = 0;
    want_strobes    = 0;

    void'($urandom(SEED));
    tbl_settle[ROWS-1] = $urandom % 16;
    tbl_dur[ROWS-1]    = $urandom % 41;

    // rows plus one trailing sample and a quiet stretch each
    cycle_limit = RESET_CYCLES + QUIET_CYCLES + 200;
    for (r = 0; r < ROWS; r++)
    begin
      cycle_limit = cycle_limit + (tbl_count[r] + 2) * (tbl_settle[r] + tbl_dur[r] + 6);
      cycle_limit = cycle_limit + QUIET_CYCLES + 2;
      want_strobes = want_strobes + tbl_count[r];
    end
    // run drops while the next sample is already under way, so it reports too
    want_strobes = want_strobes + ROWS;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // idle with run low, outputs must stay quiet
    repeat (QUIET_CYCLES) @(posedge clk);

    for (r = 0; r < ROWS; r++)
      apply_row(r);

    if (sb_strobes != want_strobes)
    begin
      bench_errors = bench_errors + 1;
      $display("error: %0d strobes seen, %0d wanted", sb_strobes, want_strobes);
    end

    assert_fails = dut_i.adc_i.chk_i.fail_total;
    $display("strobes %0d, scoreboard errors %0d, assertion failures %0d, bench errors %0d",
             sb_strobes, sb_errors, assert_fails, bench_errors);
    if ((sb_errors == 0) && (assert_fails == 0) && (bench_errors == 0))
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/meas_pkg.sv
logic/adc_timer.sv
logic/az_sequencer.sv
logic/meas_top.sv
bench/meas_checker.sv
bench/meas_scoreboard.sv
bench/meas_tb.sv

// File: logic/adc_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "meas_defines.svh"

module adc_timer (
  input  wire                   clk,
  input  wire                   reset,
  input  wire [`MEAS_DUR_W-1:0] sample_duration,
  input  wire                   adc_start,
  output logic                  adc_busy,
  output logic                  adc_done,
  output logic                  start_mark
);
  import meas_pkg::*;

  localparam logic [`MEAS_DUR_W-1:0] DUR_ONE = 1;

  adc_state_t               state;
  logic [`MEAS_DUR_W-1:0]   count_down;
  logic                     accept;

  // a start is only taken while idle and not busy
  // a start during busy is dropped here
  assign accept = (state == IDLE) && adc_start && !adc_busy;

  // integration down-counter
  // loaded in ARM, runs only while integrating
  always_ff @(posedge clk)
  begin
    if (state == ARM)
      count_down <= sample_duration;
    else if ((state == INTEGRATE) && (count_down != '0))
      count_down <= count_down - DUR_ONE;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= IDLE;
      adc_busy   <= 1'b0;
      adc_done   <= 1'b0;
      start_mark <= 1'b0;
    end
    else
    begin
      // done and the arm mark are single-cycle strobes
      adc_done   <= 1'b0;
      start_mark <= 1'b0;

      // busy drops the edge after done was raised
      if (adc_done)
        adc_busy <= 1'b0;

      case (state)
        IDLE:
        begin
          // wait for the sequencer to trigger a measurement
          if (accept)
          begin
            state    <= ARM;
            adc_busy <= 1'b1;
          end
        end

        ARM:
        begin
          // counter picks up the duration on this edge
          state      <= INTEGRATE;
          start_mark <= 1'b1;
        end

        INTEGRATE:
        begin
          // D extra cycles here before finishing
          if (count_down == '0)
            state <= FINISH;
        end

        FINISH:
        begin
          // report the measurement, busy still high this cycle
          adc_done <= 1'b1;
          state    <= IDLE;
        end

        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/az_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "meas_defines.svh"

module az_sequencer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      run,
  input  wire                      az_enable,
  input  wire [`MEAS_SETTLE_W-1:0] settle_duration,
  input  wire                      adc_busy,
  input  wire                      adc_done,
  output logic                     adc_start,
  output logic                     az_switch,
  output logic                     sample_valid,
  output meas_pkg::sample_kind_t   sample_kind,
  output logic [`MEAS_SEQ_W-1:0]   sample_seq
);
  import meas_pkg::*;

  localparam logic [`MEAS_SETTLE_W-1:0] SETTLE_ONE = 1;
  localparam logic [`MEAS_SEQ_W-1:0]    SEQ_ONE    = 1;

  seq_state_t                 state;
  logic [`MEAS_SETTLE_W-1:0]  settle_count;
  sample_kind_t               cur_kind;
  sample_kind_t               next_kind;
  logic [`MEAS_SEQ_W-1:0]     seq_count;

  // input for the sample about to begin
  // with auto-zero off it is always the signal
  // otherwise flip from the previous one
  always_comb
  begin
    if (!az_enable)
      next_kind = KIND_SIGNAL;
    else if (cur_kind == KIND_ZERO)
      next_kind = KIND_SIGNAL;
    else
      next_kind = KIND_ZERO;
  end

  // start strobe lasts the single START cycle
  // the previous measurement has always ended by then
  assign adc_start = (state == START);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= HALT;
      settle_count <= '0;
      cur_kind     <= KIND_SIGNAL;
      az_switch    <= 1'b0;
      sample_valid <= 1'b0;
      sample_kind  <= KIND_SIGNAL;
      sample_seq   <= '0;
      seq_count    <= '0;
    end
    else
    begin
      sample_valid <= 1'b0;

      case (state)
        HALT:
        begin
          // park on the signal input
          // pretending the last sample was signal makes the next one zero
          az_switch <= 1'b0;
          cur_kind  <= KIND_SIGNAL;
          if (run)
            state <= SWITCH;
        end

        SWITCH:
        begin
          // settle period and mode are taken here for the whole sample
          cur_kind     <= next_kind;
          az_switch    <= (next_kind == KIND_ZERO);
          settle_count <= settle_duration;
          if (settle_duration == '0)
            state <= START;
          else
            state <= SETTLE;
        end

        SETTLE:
        begin
          // S cycles in here, last one when the count reads one
          if (settle_count <= SETTLE_ONE)
            state <= START;
          else
            settle_count <= settle_count - SETTLE_ONE;
        end

        START:
        begin
          if (!adc_busy)
            state <= WAIT;
        end

        WAIT:
        begin
          // tag and report the finished measurement
          // switch keeps its value through the strobe cycle
          if (adc_done)
          begin
            sample_valid <= 1'b1;
            sample_kind  <= cur_kind;
            sample_seq   <= seq_count;
            seq_count    <= seq_count + SEQ_ONE;
            if (run)
              state <= SWITCH;
            else
              state <= HALT;
          end
        end

        default:
        begin
          state <= HALT;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/meas_defines.svh
`ifndef MEAS_DEFINES_SVH
`define MEAS_DEFINES_SVH

// integration period in clocks, wide enough for long samples
`define MEAS_DUR_W 32

// settle period in clocks after the input switch moves
`define MEAS_SETTLE_W 16

// sample sequence number, wraps freely
`define MEAS_SEQ_W 8

// width of the debug monitor byte
`define MEAS_MON_W 8

// monitor bit positions
// start is the one-cycle arm mark from the timer
`define MON_START 0
// level copy of the input switch
`define MON_SWITCH 1
// timer busy level
`define MON_BUSY 2
// sample strobe as it leaves the core
`define MON_VALID 3

`endif

// File: logic/meas_pkg.sv
`default_nettype none

package meas_pkg;

  // which analog input the switch had selected for a sample
  // zero is the shorted reference used for offset removal
  typedef enum logic {
    KIND_ZERO   = 1'b0,
    KIND_SIGNAL = 1'b1
  } sample_kind_t;

  // adc timer states
  // IDLE waits for start, ARM loads the period,
  // INTEGRATE counts it down, FINISH raises done
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ARM       = 2'd1,
    INTEGRATE = 2'd2,
    FINISH    = 2'd3
  } adc_state_t;

  // auto-zero sequencer states
  // HALT parks the switch while run is low
  // SWITCH picks the input for the next sample
  // SETTLE lets the front end settle after switching
  // START hands the measurement to the adc timer
  // WAIT holds until the timer reports done
  typedef enum logic [2:0] {
    HALT   = 3'd0,
    SWITCH = 3'd1,
    SETTLE = 3'd2,
    START  = 3'd3,
    WAIT   = 3'd4
  } seq_state_t;

endpackage

`default_nettype wire

// File: logic/meas_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "meas_defines.svh"

module meas_top (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      run,
  input  wire                      az_enable,
  input  wire [`MEAS_SETTLE_W-1:0] settle_duration,
  input  wire [`MEAS_DUR_W-1:0]    sample_duration,
  output logic                     az_switch,
  output logic                     sample_valid,
  output meas_pkg::sample_kind_t   sample_kind,
  output logic [`MEAS_SEQ_W-1:0]   sample_seq,
  output logic [`MEAS_MON_W-1:0]   monitor
);

  logic                    adc_start;
  logic                    adc_busy;
  logic                    adc_done;
  logic                    start_mark;
  logic [`MEAS_MON_W-1:0]  monitor_next;

  // auto-zero control, the only source of adc starts
  az_sequencer seq_i (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .az_enable       (az_enable),
    .settle_duration (settle_duration),
    .adc_busy        (adc_busy),
    .adc_done        (adc_done),
    .adc_start       (adc_start),
    .az_switch       (az_switch),
    .sample_valid    (sample_valid),
    .sample_kind     (sample_kind),
    .sample_seq      (sample_seq)
  );

  // integration period timer
  adc_timer adc_i (
    .clk             (clk),
    .reset           (reset),
    .sample_duration (sample_duration),
    .adc_start       (adc_start),
    .adc_busy        (adc_busy),
    .adc_done        (adc_done),
    .start_mark      (start_mark)
  );

  // debug byte, unused bits stay low
  always_comb
  begin
    monitor_next              = '0;
    monitor_next[`MON_START]  = start_mark;
    monitor_next[`MON_SWITCH] = az_switch;
    monitor_next[`MON_BUSY]   = adc_busy;
    monitor_next[`MON_VALID]  = sample_valid;
  end

  // one register stage so the pins see clean edges
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      monitor <= '0;
    else
      monitor <= monitor_next;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module meas_tb -f build.f -o meas_sim

status=0
./obj_dir/meas_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation did not complete"
  exit 1
fi
echo "simulation passed"
